// ==== common/vec_consts.svh ====
// vector unit constants
`ifndef VEC_CONSTS_SVH
`define VEC_CONSTS_SVH

// register file geometry
`define VEC_NREGS           8
`define VEC_XLEN            64

// apb byte address map
// v0..v7 sit at 0x00..0x38, one 64-bit word each
`define VEC_ADDR_VREG_LAST  8'h38
`define VEC_ADDR_CMD        8'h40   // command, write starts an operation
`define VEC_ADDR_STAT       8'h48   // status, bit 0 is busy

`endif

// ==== common/vec_pkg.sv ====
// vector unit shared types
`include "vec_consts.svh"

package vec_pkg;

    typedef logic [`VEC_XLEN-1:0] bus64_t;

    // element width
    typedef enum logic [1:0] {
        SEW_8  = 2'd0,
        SEW_16 = 2'd1,
        SEW_32 = 2'd2,
        SEW_64 = 2'd3
    } sew_t;

    typedef enum logic {
        VADD = 1'b0,
        VSUB = 1'b1    // vd = vs2 - vs1
    } vop_t;

    typedef logic [$clog2(`VEC_NREGS)-1:0] vreg_idx_t;

    // command word, low bits of the apb write data
    typedef struct packed {
        vop_t      op;
        sew_t      sew;
        vreg_idx_t vd;
        vreg_idx_t vs1;
        vreg_idx_t vs2;
    } vcmd_t;

    // one register file access
    typedef struct packed {
        logic      en;
        logic      we;
        vreg_idx_t addr;
        bus64_t    wdata;
    } rf_req_t;

endpackage

// ==== vector_alu/vaddsub.sv ====
// packed simd add and subtract
`timescale 1ns/1ps

module vaddsub (
    input  vec_pkg::vop_t   instr_type_i,
    input  vec_pkg::sew_t   sew_i,
    input  vec_pkg::bus64_t data_vs1_i,
    input  vec_pkg::bus64_t data_vs2_i,
    output vec_pkg::bus64_t data_vd_o
);
    import vec_pkg::*;

    localparam int NLANES = $bits(bus64_t) / 8;

    logic              is_sub;
    bus64_t            opnd_b;      // vs1, inverted for subtract
    logic [NLANES-1:0] chain;       // lane takes the carry of the lane below
    logic [8:0]        lane_sum;
    logic              carry;

    assign is_sub = (instr_type_i == VSUB);
    assign opnd_b = is_sub ? ~data_vs1_i : data_vs1_i;

    // a lane that starts a new element breaks the chain
    always_comb begin
        for (int i = 0; i < NLANES; i++) begin
            case (sew_i)
                SEW_8:   chain[i] = 1'b0;
                SEW_16:  chain[i] = (i % 2) != 0;
                SEW_32:  chain[i] = (i % 4) != 0;
                default: chain[i] = (i != 0);
            endcase
        end
    end

    // ripple through the byte lanes, low lane first
    always_comb begin
        carry     = is_sub;
        lane_sum  = '0;
        data_vd_o = '0;
        for (int i = 0; i < NLANES; i++) begin
            if (!chain[i]) begin
                carry = is_sub;    // injected carry, one for two's complement
            end
            lane_sum = {1'b0, data_vs2_i[8*i +: 8]} + {1'b0, opnd_b[8*i +: 8]}
                     + {8'b0, carry};
            data_vd_o[8*i +: 8] = lane_sum[7:0];
            carry = lane_sum[8];
        end
    end

endmodule

// ==== vector_alu/vec_exec.sv ====
// vector execute sequencer
`timescale 1ns/1ps

module vec_exec (
    input  logic             clk_i,
    input  logic             rst_i,
    input  logic             cmd_valid_i,
    input  vec_pkg::vcmd_t   cmd_i,
    output logic             busy_o,
    output vec_pkg::rf_req_t req_o,
    input  logic             gnt_i,
    input  logic             rvalid_i,
    input  vec_pkg::bus64_t  rdata_i
);
    import vec_pkg::*;

    typedef enum logic [2:0] {
        EX_IDLE,
        EX_RD1,     // request vs1
        EX_RD2,     // request vs2, vs1 data returns here
        EX_WAIT,    // vs2 data returns
        EX_WR       // write vd
    } ex_state_t;

    ex_state_t state_q;
    vcmd_t     cmd_q;
    bus64_t    vs1_q;
    bus64_t    vd_q;
    bus64_t    sum;

    vaddsub i_vaddsub (
        .instr_type_i (cmd_q.op),
        .sew_i        (cmd_q.sew),
        .data_vs1_i   (vs1_q),
        .data_vs2_i   (rdata_i),    // vs2 straight from the register file
        .data_vd_o    (sum)
    );

    assign busy_o = (state_q != EX_IDLE);

    always_comb begin
        req_o.en    = 1'b0;
        req_o.we    = 1'b0;
        req_o.addr  = cmd_q.vs1;
        req_o.wdata = vd_q;
        case (state_q)
            EX_RD1: req_o.en = 1'b1;
            EX_RD2: begin
                req_o.en   = 1'b1;
                req_o.addr = cmd_q.vs2;
            end
            EX_WR: begin
                req_o.en   = 1'b1;
                req_o.we   = 1'b1;
                req_o.addr = cmd_q.vd;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= EX_IDLE;
        end else begin
            case (state_q)
                EX_IDLE: if (cmd_valid_i) begin
                    state_q <= EX_RD1;
                end
                EX_RD1:  if (gnt_i) begin
                    state_q <= EX_RD2;
                end
                EX_RD2:  if (gnt_i) begin
                    state_q <= EX_WAIT;
                end
                EX_WAIT: if (rvalid_i) begin
                    state_q <= EX_WR;
                end
                EX_WR:   if (gnt_i) begin
                    state_q <= EX_IDLE;
                end
                default: state_q <= EX_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == EX_IDLE && cmd_valid_i) begin
            cmd_q <= cmd_i;
        end
        if (state_q == EX_RD2 && rvalid_i) begin
            vs1_q <= rdata_i;
        end
        if (state_q == EX_WAIT && rvalid_i) begin
            vd_q <= sum;    // result held for the write cycle
        end
    end

endmodule

// ==== design/vec_regfile.sv ====
// vector register file
`timescale 1ns/1ps
`include "vec_consts.svh"

module vec_regfile (
    input  logic             clk_i,
    input  logic             rst_i,
    input  vec_pkg::rf_req_t req_i,
    output vec_pkg::bus64_t  rdata_o
);
    import vec_pkg::*;

    bus64_t regs_q [`VEC_NREGS];

    // single port, one access per cycle
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 0; i < `VEC_NREGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (req_i.en && req_i.we) begin
            regs_q[req_i.addr] <= req_i.wdata;
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_i.en && !req_i.we) begin
            rdata_o <= regs_q[req_i.addr];   // valid the cycle after the grant
        end
    end

endmodule

// ==== design/vrf_arbiter.sv ====
// register file port arbiter
`timescale 1ns/1ps

module vrf_arbiter (
    input  logic             clk_i,
    input  logic             rst_i,
    input  vec_pkg::rf_req_t exec_req_i,
    input  vec_pkg::rf_req_t host_req_i,
    output logic             exec_gnt_o,
    output logic             host_gnt_o,
    output logic             exec_rvalid_o,
    output logic             host_rvalid_o,
    output vec_pkg::rf_req_t rf_req_o
);

    // fixed priority, execute engine first
    assign exec_gnt_o = exec_req_i.en;
    assign host_gnt_o = host_req_i.en && !exec_req_i.en;

    assign rf_req_o = exec_req_i.en ? exec_req_i : host_req_i;

    // remember who owns the read in flight
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            exec_rvalid_o <= 1'b0;
            host_rvalid_o <= 1'b0;
        end else begin
            exec_rvalid_o <= exec_gnt_o && !exec_req_i.we;
            host_rvalid_o <= host_gnt_o && !host_req_i.we;
        end
    end

endmodule

// ==== design/apb_vec_slave.sv ====
// apb slave for the vector unit
`timescale 1ns/1ps
`include "vec_consts.svh"

module apb_vec_slave (
    input  logic             clk_i,
    input  logic             rst_i,
    input  logic             psel_i,
    input  logic             penable_i,
    input  logic             pwrite_i,
    input  logic [7:0]       paddr_i,
    input  vec_pkg::bus64_t  pwdata_i,
    output vec_pkg::bus64_t  prdata_o,
    output logic             pready_o,
    output logic             pslverr_o,
    input  logic             busy_i,
    output logic             cmd_valid_o,
    output vec_pkg::vcmd_t   cmd_o,
    output vec_pkg::rf_req_t req_o,
    input  logic             gnt_i,
    input  logic             rvalid_i,
    input  vec_pkg::bus64_t  rdata_i
);
    import vec_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REQ,     // request held until granted
        ST_RDATA    // read granted, data next
    } state_t;

    state_t    state_q;
    logic      access;
    logic      hit_vreg;
    logic      hit_cmd;
    logic      hit_stat;
    logic      cmd_ok;
    logic      req_we_q;
    vreg_idx_t req_addr_q;
    bus64_t    req_wdata_q;

    assign access   = psel_i && penable_i;
    assign hit_vreg = (paddr_i <= `VEC_ADDR_VREG_LAST) && (paddr_i[2:0] == 3'd0);
    assign hit_cmd  = (paddr_i == `VEC_ADDR_CMD);
    assign hit_stat = (paddr_i == `VEC_ADDR_STAT);
    assign cmd_ok   = !busy_i && !cmd_valid_o;   // also covers the cycle before busy

    assign req_o.en    = (state_q == ST_REQ);
    assign req_o.we    = req_we_q;
    assign req_o.addr  = req_addr_q;
    assign req_o.wdata = req_wdata_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= ST_IDLE;
        end else begin
            case (state_q)
                ST_IDLE:  if (access && hit_vreg) begin
                    state_q <= ST_REQ;
                end
                ST_REQ:   if (gnt_i) begin
                    state_q <= req_we_q ? ST_IDLE : ST_RDATA;
                end
                ST_RDATA: if (rvalid_i) begin
                    state_q <= ST_IDLE;
                end
                default:  state_q <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == ST_IDLE && access && hit_vreg) begin
            req_we_q    <= pwrite_i;
            req_addr_q  <= paddr_i[5:3];    // 8 bytes per register
            req_wdata_q <= pwdata_i;
        end
        if (access && hit_cmd && pwrite_i && cmd_ok) begin
            cmd_o <= vcmd_t'(pwdata_i[$bits(vcmd_t)-1:0]);
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            cmd_valid_o <= 1'b0;
        end else begin
            cmd_valid_o <= access && hit_cmd && pwrite_i && cmd_ok;
        end
    end

    // command and status finish in the first access cycle
    always_comb begin
        pready_o  = 1'b0;
        pslverr_o = 1'b0;
        prdata_o  = '0;
        if (access) begin
            if (hit_vreg) begin
                pready_o = (state_q == ST_REQ && gnt_i && req_we_q)
                        || (state_q == ST_RDATA && rvalid_i);
                prdata_o = rdata_i;
            end else if (hit_cmd) begin
                pready_o  = 1'b1;
                pslverr_o = pwrite_i && !cmd_ok;   // dropped while busy
                prdata_o  = bus64_t'(cmd_o);
            end else if (hit_stat) begin
                pready_o = 1'b1;
                prdata_o = bus64_t'(busy_i || cmd_valid_o);
            end else begin
                pready_o  = 1'b1;
                pslverr_o = 1'b1;
            end
        end
    end

endmodule

// ==== design/vec_unit_top.sv ====
// vector unit top level
`timescale 1ns/1ps

module vec_unit_top (
    input  logic            clk_i,
    input  logic            rst_i,
    input  logic            psel_i,
    input  logic            penable_i,
    input  logic            pwrite_i,
    input  logic [7:0]      paddr_i,
    input  vec_pkg::bus64_t pwdata_i,
    output vec_pkg::bus64_t prdata_o,
    output logic            pready_o,
    output logic            pslverr_o
);
    import vec_pkg::*;

    rf_req_t host_req;
    rf_req_t exec_req;
    rf_req_t rf_req;
    logic    host_gnt;
    logic    exec_gnt;
    logic    host_rvalid;
    logic    exec_rvalid;
    bus64_t  rf_rdata;     // broadcast to both peers
    vcmd_t   cmd;
    logic    cmd_valid;
    logic    busy;

    apb_vec_slave i_apb_vec_slave (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .psel_i      (psel_i),
        .penable_i   (penable_i),
        .pwrite_i    (pwrite_i),
        .paddr_i     (paddr_i),
        .pwdata_i    (pwdata_i),
        .prdata_o    (prdata_o),
        .pready_o    (pready_o),
        .pslverr_o   (pslverr_o),
        .busy_i      (busy),
        .cmd_valid_o (cmd_valid),
        .cmd_o       (cmd),
        .req_o       (host_req),
        .gnt_i       (host_gnt),
        .rvalid_i    (host_rvalid),
        .rdata_i     (rf_rdata)
    );

    vec_exec i_vec_exec (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .cmd_valid_i (cmd_valid),
        .cmd_i       (cmd),
        .busy_o      (busy),
        .req_o       (exec_req),
        .gnt_i       (exec_gnt),
        .rvalid_i    (exec_rvalid),
        .rdata_i     (rf_rdata)
    );

    vrf_arbiter i_vrf_arbiter (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .exec_req_i    (exec_req),
        .host_req_i    (host_req),
        .exec_gnt_o    (exec_gnt),
        .host_gnt_o    (host_gnt),
        .exec_rvalid_o (exec_rvalid),
        .host_rvalid_o (host_rvalid),
        .rf_req_o      (rf_req)
    );

    vec_regfile i_vec_regfile (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .req_i   (rf_req),
        .rdata_o (rf_rdata)
    );

endmodule

// ==== sim/vec_unit_chk.sv ====
// vector unit assertions
`timescale 1ns/1ps

module vec_unit_chk (
    input logic clk_i,
    input logic rst_i,
    input logic pready_i,
    input logic pslverr_i,
    input logic host_gnt_i,
    input logic exec_gnt_i,
    input logic host_rd_i,      // host request is a read
    input logic exec_rd_i,
    input logic host_rvalid_i,
    input logic exec_rvalid_i
);

    // error response only on the completing cycle
    a_slverr_ready: assert property (@(posedge clk_i) disable iff (rst_i)
        pslverr_i |-> pready_i)
        else $error("pslverr high while pready low");

    a_one_grant: assert property (@(posedge clk_i) disable iff (rst_i)
        !(host_gnt_i && exec_gnt_i))
        else $error("both register file grants high");

    a_host_rvalid: assert property (@(posedge clk_i) disable iff (rst_i)
        host_rvalid_i |-> $past(host_gnt_i && host_rd_i))
        else $error("host rvalid without a host read grant");

    a_exec_rvalid: assert property (@(posedge clk_i) disable iff (rst_i)
        exec_rvalid_i |-> $past(exec_gnt_i && exec_rd_i))
        else $error("exec rvalid without an exec read grant");

endmodule

bind vec_unit_top vec_unit_chk i_vec_unit_chk (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .pready_i      (pready_o),
    .pslverr_i     (pslverr_o),
    .host_gnt_i    (host_gnt),
    .exec_gnt_i    (exec_gnt),
    .host_rd_i     (!host_req.we),
    .exec_rd_i     (!exec_req.we),
    .host_rvalid_i (host_rvalid),
    .exec_rvalid_i (exec_rvalid)
);

// ==== sim/vec_unit_tb.sv ====
// vector unit testbench
`timescale 1ns/1ps
`include "vec_consts.svh"

module vec_unit_tb;
    import vec_pkg::*;

    localparam int MAX_OPS        = 120;
    localparam int MAX_OP_CYCLES  = 20;
    localparam int TIMEOUT_CYCLES = 2 * MAX_OPS * MAX_OP_CYCLES + 200;   // 5000

    logic        clk_i;
    logic        rst_i;
    logic        psel_i;
    logic        penable_i;
    logic        pwrite_i;
    logic [7:0]  paddr_i;
    bus64_t      pwdata_i;
    bus64_t      prdata_o;
    logic        pready_o;
    logic        pslverr_o;

    bus64_t      shadow [`VEC_NREGS];   // expected register contents
    bus64_t      exp_q [$];
    bus64_t      got_q [$];
    int          tag_q [$];             // register index of each read
    logic [31:0] lfsr_q;
    int          cycle_cnt = 0;
    int          errors = 0;
    int          issued = 0;
    int          compared = 0;

    vec_unit_top i_vec_unit_top (.*);

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    initial begin
        wait (cycle_cnt >= TIMEOUT_CYCLES);
        $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Simulation finished: FAIL");
        $finish;
    end

    function automatic void report_error(string msg);
        errors++;
        $display("FAILED at %0d ns: %s", $time, msg);
    endfunction

    // galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    function automatic bus64_t rand_word();
        bus64_t v;
        v = '0;
        for (int i = 0; i < 64; i++) begin
            lfsr_q = lfsr_step(lfsr_q);    // one step per bit
            v = {v[62:0], lfsr_q[0]};
        end
        return v;
    endfunction

    // expected vd, element by element modulo the element width
    function automatic bus64_t ref_vop(vop_t op, sew_t sew, bus64_t vs1, bus64_t vs2);
        int     w;
        bus64_t mask;
        bus64_t e1;
        bus64_t e2;
        bus64_t r;
        bus64_t res;
        w    = 8 << int'(sew);
        mask = {64{1'b1}} >> (64 - w);
        res  = '0;
        for (int i = 0; i < 64; i += w) begin
            e1 = (vs1 >> i) & mask;
            e2 = (vs2 >> i) & mask;
            r  = (op == VSUB) ? (e2 - e1) : (e2 + e1);
            res |= (r & mask) << i;
        end
        return res;
    endfunction

    function automatic bus64_t one_per_elem(sew_t sew);
        bus64_t v;
        v = '0;
        for (int i = 0; i < 64; i += (8 << int'(sew))) begin
            v[i] = 1'b1;
        end
        return v;
    endfunction

    function automatic bus64_t cmd_word(vop_t op, sew_t sew, int vd, int vs1, int vs2);
        vcmd_t c;
        c.op  = op;
        c.sew = sew;
        c.vd  = vreg_idx_t'(vd);
        c.vs1 = vreg_idx_t'(vs1);
        c.vs2 = vreg_idx_t'(vs2);
        return bus64_t'(c);
    endfunction

    // tasks are entered and left on a falling edge
    task automatic apb_write(input logic [7:0] addr, input bus64_t data, output logic err);
        psel_i    = 1'b1;
        penable_i = 1'b0;
        pwrite_i  = 1'b1;
        paddr_i   = addr;
        pwdata_i  = data;
        @(negedge clk_i);
        penable_i = 1'b1;
        #1;
        while (!pready_o) begin
            @(negedge clk_i);
            #1;
        end
        err = pslverr_o;
        @(negedge clk_i);
        psel_i    = 1'b0;
        penable_i = 1'b0;
    endtask

    task automatic apb_read(input logic [7:0] addr, output bus64_t data, output logic err,
                            output int lat);
        psel_i    = 1'b1;
        penable_i = 1'b0;
        pwrite_i  = 1'b0;
        paddr_i   = addr;
        @(negedge clk_i);
        penable_i = 1'b1;
        lat = 1;    // access cycles, completing one included
        #1;
        while (!pready_o) begin
            @(negedge clk_i);
            #1;
            lat++;
        end
        data = prdata_o;
        err  = pslverr_o;
        @(negedge clk_i);
        psel_i    = 1'b0;
        penable_i = 1'b0;
    endtask

    task automatic write_reg(input int idx, input bus64_t data);
        logic err;
        apb_write(8'(idx * 8), data, err);
        if (err) begin
            report_error($sformatf("pslverr on write of v%0d", idx));
        end
        shadow[idx] = data;
    endtask

    task automatic check_reg(input int idx, output int lat);
        bus64_t data;
        logic   err;
        exp_q.push_back(shadow[idx]);
        apb_read(8'(idx * 8), data, err, lat);
        if (err) begin
            report_error($sformatf("pslverr on read of v%0d", idx));
        end
        tag_q.push_back(idx);
        got_q.push_back(data);
        issued++;
    endtask

    task automatic wait_idle();
        bus64_t st;
        logic   err;
        int     lat;
        st = 64'd1;
        while (st[0]) begin
            apb_read(`VEC_ADDR_STAT, st, err, lat);
        end
    endtask

    task automatic run_cmd(input vop_t op, input sew_t sew, input int vd, input int vs1,
                           input int vs2);
        logic err;
        int   lat;
        apb_write(`VEC_ADDR_CMD, cmd_word(op, sew, vd, vs1, vs2), err);
        if (err) begin
            report_error("pslverr on a command written while idle");
        end
        shadow[vd] = ref_vop(op, sew, shadow[vs1], shadow[vs2]);
        wait_idle();
        check_reg(vd, lat);
    endtask

    // compares every register read against the shadow copy
    initial begin
        bus64_t got;
        bus64_t exp;
        int     idx;
        forever begin
            wait (got_q.size() > 0);
            got = got_q.pop_front();
            exp = exp_q.pop_front();
            idx = tag_q.pop_front();
            if (got !== exp) begin
                report_error($sformatf("v%0d read %h, expected %h", idx, got, exp));
            end
            compared++;
        end
    end

    initial begin
        bus64_t data;
        logic   err;
        int     lat;
        sew_t   sew;

        rst_i     = 1'b1;
        psel_i    = 1'b0;
        penable_i = 1'b0;
        pwrite_i  = 1'b0;
        paddr_i   = 8'h00;
        pwdata_i  = '0;
        lfsr_q    = 32'h3be01cd2;
        for (int i = 0; i < `VEC_NREGS; i++) begin
            shadow[i] = '0;
        end
        repeat (3) @(posedge clk_i);
        @(negedge clk_i);
        rst_i = 1'b0;

        apb_read(`VEC_ADDR_STAT, data, err, lat);
        if (err || data !== 64'd0) begin
            report_error($sformatf("status after reset %h, expected idle", data));
        end
        for (int i = 0; i < `VEC_NREGS; i++) begin
            check_reg(i, lat);      // zeros after reset
        end
        for (int i = 0; i < `VEC_NREGS; i++) begin
            write_reg(i, rand_word());
        end
        for (int i = 0; i < `VEC_NREGS; i++) begin
            check_reg(i, lat);
        end

        for (int s = 0; s < 4; s++) begin
            sew = sew_t'(s);
            write_reg(s, rand_word());
            write_reg(s + 4, rand_word());
            run_cmd(VADD, sew, 7 - s, s, s + 4);
            write_reg(s, rand_word());
            run_cmd(VSUB, sew, (s % 2 == 0) ? s : s + 4, s, s + 4);   // vd overlaps a source
        end

        // carries must stop at element boundaries
        for (int s = 0; s < 4; s++) begin
            sew = sew_t'(s);
            write_reg(0, '1);
            write_reg(1, one_per_elem(sew));
            write_reg(3, '0);
            run_cmd(VADD, sew, 2, 1, 0);
            run_cmd(VSUB, sew, 4, 1, 3);
        end

        // second command while busy is dropped
        write_reg(0, rand_word());
        write_reg(1, rand_word());
        apb_write(`VEC_ADDR_CMD, cmd_word(VADD, SEW_32, 5, 0, 1), err);
        if (err) begin
            report_error("pslverr on a command written while idle");
        end
        shadow[5] = ref_vop(VADD, SEW_32, shadow[0], shadow[1]);
        apb_read(`VEC_ADDR_STAT, data, err, lat);
        if (data[0] !== 1'b1) begin
            report_error("status did not show busy right after a command");
        end
        apb_write(`VEC_ADDR_CMD, cmd_word(VSUB, SEW_8, 6, 0, 1), err);
        if (!err) begin
            report_error("command written while busy was not rejected");
        end
        wait_idle();
        check_reg(5, lat);
        check_reg(6, lat);          // untouched by the dropped command

        // host read held off by the execute engine
        apb_write(`VEC_ADDR_CMD, cmd_word(VSUB, SEW_16, 2, 0, 1), err);
        if (err) begin
            report_error("pslverr on a command written while idle");
        end
        shadow[2] = ref_vop(VSUB, SEW_16, shadow[0], shadow[1]);
        check_reg(0, lat);
        if (lat <= 3) begin
            report_error($sformatf("read during execution took %0d cycles, no wait", lat));
        end
        wait_idle();
        check_reg(2, lat);

        // unmapped and unaligned addresses
        apb_write(8'h50, rand_word(), err);
        if (!err) begin
            report_error("write to unmapped address 0x50 gave no pslverr");
        end
        apb_write(8'h0c, rand_word(), err);
        if (!err) begin
            report_error("write to unaligned address 0x0c gave no pslverr");
        end
        apb_read(8'h44, data, err, lat);
        if (!err) begin
            report_error("read of unmapped address 0x44 gave no pslverr");
        end
        for (int i = 0; i < `VEC_NREGS; i++) begin
            check_reg(i, lat);
        end

        wait (compared == issued);
        $display("register reads compared: %0d, errors: %0d", compared, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
+incdir+common
common/vec_pkg.sv
vector_alu/vaddsub.sv
vector_alu/vec_exec.sv
design/vec_regfile.sv
design/vrf_arbiter.sv
design/apb_vec_slave.sv
design/vec_unit_top.sv
sim/vec_unit_chk.sv
sim/vec_unit_tb.sv
